//--- logic/ovl_pkg.sv
package ovl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // One 8x8 cell of the overlay, at most 1024 of them
    typedef logic [9:0] cell_addr_t;

    // Palette index held per cell
    typedef logic [3:0] pal_idx_t;

    // Red in the top nibble, then green, blue at the bottom
    typedef logic [11:0] rgb_t;

    typedef logic [7:0] spi_byte_t;

    // Raster position, good for lines up to 2048 pixels
    typedef logic [10:0] coord_t;

    localparam int PAL_ENTRIES = 16;

    //////////////////////////////////////////////////////////////////////
    // Message decoding
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,
        ADDR_LO,
        ADDR_HI,
        DATA_LO,
        DATA_HI,
        DISCARD
    } msg_state_t;

    typedef enum logic {
        CELLS,
        PALETTE
    } wr_target_t;

    localparam spi_byte_t CMD_CELL_WR = 8'h20;
    localparam spi_byte_t CMD_PAL_WR  = 8'h21;

endpackage

//--- logic/ovl_wr_if.sv
interface ovl_wr_if;
    import ovl_pkg::*;

    logic       wr;
    wr_target_t target;
    cell_addr_t addr;
    // Full colour for the palette, index in the low nibble for cells
    rgb_t       wrdata;

    modport src (
        output wr,
        output target,
        output addr,
        output wrdata
    );

    modport dst (
        input  wr,
        input  target,
        input  addr,
        input  wrdata
    );

endinterface

//--- logic/spi_byte_rx.sv
module spi_byte_rx (
    input  logic               clk,
    input  logic               reset,
    input  logic               esp_sclk,
    input  logic               esp_mosi,
    input  logic               esp_ssel_n,
    output logic               byte_valid,
    output ovl_pkg::spi_byte_t byte_data,
    output logic               msg_end
);
    import ovl_pkg::*;

    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] ssel_sync;
    logic       sclk_prev;
    logic       ssel_prev;
    logic [2:0] bit_cnt;
    spi_byte_t  shift_q;
    logic       sclk_rise;
    logic       ssel_rise;

    // Edges seen on the synchronized pins
    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign ssel_rise = ssel_sync[1] & ~ssel_prev;

    // Shift register holds the finished byte while byte_valid is high
    assign byte_data = shift_q;

    //////////////////////////////////////////////////////////////////////
    // Pin synchronizers and framing
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            sclk_sync  <= 2'b00;
            mosi_sync  <= 2'b00;
            ssel_sync  <= 2'b11;
            sclk_prev  <= 1'b0;
            ssel_prev  <= 1'b1;
            bit_cnt    <= 3'd0;
            byte_valid <= 1'b0;
            msg_end    <= 1'b0;
        end else begin
            sclk_sync  <= {sclk_sync[0], esp_sclk};
            mosi_sync  <= {mosi_sync[0], esp_mosi};
            ssel_sync  <= {ssel_sync[0], esp_ssel_n};
            sclk_prev  <= sclk_sync[1];
            ssel_prev  <= ssel_sync[1];
            byte_valid <= 1'b0;
            msg_end    <= ssel_rise;

            // Deselected: a partial byte is thrown away
            if (ssel_sync[1]) begin
                bit_cnt <= 3'd0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7)
                    byte_valid <= 1'b1;
            end
        end
    end

    // MSB first, sampled on the rising edge of sclk
    always_ff @(posedge clk) begin
        if (sclk_rise && !ssel_sync[1])
            shift_q <= {shift_q[6:0], mosi_sync[1]};
    end

endmodule

//--- logic/spi_msg_fsm.sv
module spi_msg_fsm (
    input  logic               clk,
    input  logic               reset,
    input  logic               byte_valid,
    input  ovl_pkg::spi_byte_t byte_data,
    input  logic               msg_end,
    ovl_wr_if.src              wr
);
    import ovl_pkg::*;

    localparam int AW = $bits(cell_addr_t);

    msg_state_t state;
    wr_target_t msg_target;
    cell_addr_t addr;
    cell_addr_t addr_inc;
    spi_byte_t  lo_byte;
    logic       wr_fire;

    // Palette addresses wrap at 16, cell addresses at the full width
    always_comb begin
        if (msg_target == PALETTE)
            addr_inc = {addr[AW-1:4], addr[3:0] + 4'd1};
        else
            addr_inc = addr + 1'b1;
    end

    // Every data byte for cells, every second one for the palette
    assign wr_fire = byte_valid && !msg_end &&
                     ((state == DATA_LO && msg_target == CELLS) || state == DATA_HI);

    //////////////////////////////////////////////////////////////////////
    // Message FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            msg_target <= CELLS;
            wr.wr      <= 1'b0;
        end else begin
            wr.wr <= wr_fire;

            if (msg_end) begin
                // Half-assembled palette entry is lost here
                state <= IDLE;
            end else if (byte_valid) begin
                case (state)
                    IDLE: begin
                        if (byte_data == CMD_CELL_WR) begin
                            msg_target <= CELLS;
                            state      <= ADDR_LO;
                        end else if (byte_data == CMD_PAL_WR) begin
                            msg_target <= PALETTE;
                            state      <= ADDR_LO;
                        end else begin
                            state <= DISCARD;
                        end
                    end
                    ADDR_LO: state <= ADDR_HI;
                    ADDR_HI: state <= DATA_LO;
                    DATA_LO: begin
                        if (msg_target == PALETTE)
                            state <= DATA_HI;
                    end
                    DATA_HI: state <= DATA_LO;
                    default: state <= DISCARD;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Address and write data
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            case (state)
                ADDR_LO: addr[7:0] <= byte_data;
                // Low byte first, the high byte only fills the top bits
                ADDR_HI: addr[AW-1:8] <= byte_data[AW-9:0];
                DATA_LO: lo_byte <= byte_data;
                default: ;
            endcase
        end

        if (wr_fire) begin
            wr.target <= msg_target;
            wr.addr   <= addr;
            if (msg_target == CELLS)
                wr.wrdata <= rgb_t'(byte_data[3:0]);
            else
                wr.wrdata <= {byte_data[3:0], lo_byte};
            addr <= addr_inc;
        end
    end

endmodule

//--- logic/scan_timer.sv
module scan_timer #(
    parameter int H_ACTIVE     = 64,
    parameter int V_ACTIVE     = 32,
    parameter int H_TOTAL      = 80,
    parameter int V_TOTAL      = 40,
    parameter int H_SYNC_START = 68,
    parameter int H_SYNC_LEN   = 6,
    parameter int V_SYNC_START = 34,
    parameter int V_SYNC_LEN   = 2
) (
    input  logic            clk,
    input  logic            reset,
    output ovl_pkg::coord_t x,
    output ovl_pkg::coord_t y,
    output logic            de,
    output logic            hsync,
    output logic            vsync
);
    import ovl_pkg::*;

    coord_t h_next;
    coord_t v_next;

    // Next raster position
    always_comb begin
        v_next = y;
        if (x == coord_t'(H_TOTAL - 1)) begin
            h_next = '0;
            if (y == coord_t'(V_TOTAL - 1))
                v_next = '0;
            else
                v_next = y + 1'b1;
        end else begin
            h_next = x + 1'b1;
        end
    end

    // Flags come from the next position so they line up with x and y
    always_ff @(posedge clk) begin
        if (reset) begin
            x     <= '0;
            y     <= '0;
            // Position zero lies in the active area
            de    <= 1'b1;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            x     <= h_next;
            y     <= v_next;
            de    <= (h_next < H_ACTIVE) && (v_next < V_ACTIVE);
            // Sync pulses are active low
            hsync <= !((h_next >= H_SYNC_START) && (h_next < H_SYNC_START + H_SYNC_LEN));
            vsync <= !((v_next >= V_SYNC_START) && (v_next < V_SYNC_START + V_SYNC_LEN));
        end
    end

endmodule

//--- logic/overlay_mem.sv
module overlay_mem #(
    parameter int H_ACTIVE = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  ovl_pkg::coord_t x,
    input  ovl_pkg::coord_t y,
    input  logic            de,
    input  logic            hsync,
    input  logic            vsync,
    ovl_wr_if.dst           wr,
    output logic [3:0]      vga_r,
    output logic [3:0]      vga_g,
    output logic [3:0]      vga_b,
    output logic            vga_hsync,
    output logic            vga_vsync
);
    import ovl_pkg::*;

    localparam int CELLS_PER_ROW = H_ACTIVE / 8;
    localparam int CELL_WORDS    = 2 ** $bits(cell_addr_t);

    // One entry per cell address
    pal_idx_t   cell_ram [CELL_WORDS];
    rgb_t       palette  [PAL_ENTRIES];

    cell_addr_t cell_sel;
    pal_idx_t   idx_q;
    logic       de_q1;
    logic       hsync_q1;
    logic       vsync_q1;
    rgb_t       pix_q;

    // Row of cells times cells per row plus column
    assign cell_sel = cell_addr_t'((y >> 3) * CELLS_PER_ROW + (x >> 3));

    //////////////////////////////////////////////////////////////////////
    // Cell RAM, written from SPI and read by stage one
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr.wr && wr.target == CELLS)
            cell_ram[wr.addr] <= wr.wrdata[3:0];
        idx_q <= cell_ram[cell_sel];
    end

    //////////////////////////////////////////////////////////////////////
    // Palette and stage two
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PAL_ENTRIES; i++)
                palette[i] <= '0;
        end else if (wr.wr && wr.target == PALETTE) begin
            palette[wr.addr[3:0]] <= wr.wrdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            de_q1     <= 1'b0;
            hsync_q1  <= 1'b1;
            vsync_q1  <= 1'b1;
            pix_q     <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
        end else begin
            de_q1     <= de;
            hsync_q1  <= hsync;
            vsync_q1  <= vsync;
            vga_hsync <= hsync_q1;
            vga_vsync <= vsync_q1;
            // Black outside the active area
            pix_q     <= de_q1 ? palette[idx_q] : '0;
        end
    end

    assign vga_r = pix_q[11:8];
    assign vga_g = pix_q[7:4];
    assign vga_b = pix_q[3:0];

endmodule

//--- logic/ovl_top.sv
module ovl_top #(
    parameter int H_ACTIVE     = 64,
    parameter int V_ACTIVE     = 32,
    parameter int H_TOTAL      = 80,
    parameter int V_TOTAL      = 40,
    parameter int H_SYNC_START = 68,
    parameter int H_SYNC_LEN   = 6,
    parameter int V_SYNC_START = 34,
    parameter int V_SYNC_LEN   = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       esp_ssel_n,
    input  logic       esp_sclk,
    input  logic       esp_mosi,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b,
    output logic       vga_hsync,
    output logic       vga_vsync
);
    import ovl_pkg::*;

    logic      byte_valid;
    spi_byte_t byte_data;
    logic      msg_end;

    coord_t    scan_x;
    coord_t    scan_y;
    logic      scan_de;
    logic      scan_hsync;
    logic      scan_vsync;

    ovl_wr_if ovl_wr();

    //////////////////////////////////////////////////////////////////////
    // ESP32 SPI path
    //////////////////////////////////////////////////////////////////////
    spi_byte_rx spi_rx_i (
        .clk(clk),
        .reset(reset),
        .esp_sclk(esp_sclk),
        .esp_mosi(esp_mosi),
        .esp_ssel_n(esp_ssel_n),
        .byte_valid(byte_valid),
        .byte_data(byte_data),
        .msg_end(msg_end)
    );

    spi_msg_fsm msg_fsm_i (
        .clk(clk),
        .reset(reset),
        .byte_valid(byte_valid),
        .byte_data(byte_data),
        .msg_end(msg_end),
        .wr(ovl_wr.src)
    );

    //////////////////////////////////////////////////////////////////////
    // Raster and pixel output
    //////////////////////////////////////////////////////////////////////
    scan_timer #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE),
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL),
        .H_SYNC_START(H_SYNC_START),
        .H_SYNC_LEN(H_SYNC_LEN),
        .V_SYNC_START(V_SYNC_START),
        .V_SYNC_LEN(V_SYNC_LEN)
    ) scan_i (
        .clk(clk),
        .reset(reset),
        .x(scan_x),
        .y(scan_y),
        .de(scan_de),
        .hsync(scan_hsync),
        .vsync(scan_vsync)
    );

    overlay_mem #(
        .H_ACTIVE(H_ACTIVE)
    ) mem_i (
        .clk(clk),
        .reset(reset),
        .x(scan_x),
        .y(scan_y),
        .de(scan_de),
        .hsync(scan_hsync),
        .vsync(scan_vsync),
        .wr(ovl_wr.dst),
        .vga_r(vga_r),
        .vga_g(vga_g),
        .vga_b(vga_b),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync)
    );

endmodule

//--- tb/tb_clk.sv
module tb_clk #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset drops just after the last held edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

//--- tb/ovl_checker.sv
module ovl_checker #(
    parameter int H_TOTAL      = 72,
    parameter int V_TOTAL      = 36,
    parameter int H_SYNC_START = 66,
    parameter int H_SYNC_LEN   = 3,
    parameter int V_SYNC_START = 33,
    parameter int V_SYNC_LEN   = 1
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] vga_r,
    input  logic [3:0] vga_g,
    input  logic [3:0] vga_b,
    input  logic       vga_hsync,
    input  logic       vga_vsync,
    input  logic       frame_req,
    output logic       frame_ack,
    output int         err_count,
    output int         lit_lines,
    output int         lit_pixels
);
    import ovl_pkg::*;

    int   ox;
    int   oy;
    int   line_px;
    int   hs_falls;
    int   vs_falls;
    int   hs_low;
    int   vs_low;
    logic h_locked;
    logic v_locked;
    logic hs_prev;
    logic vs_prev;
    logic checking;

    //////////////////////////////////////////////////////////////////////
    // Output position follows the sync falling edges
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin : track
        rgb_t got;
        rgb_t exp;
        logic h_fall;
        logic v_fall;
        if (reset) begin
            ox        = 0;
            oy        = 0;
            h_locked  = 1'b0;
            v_locked  = 1'b0;
            hs_prev   = 1'b1;
            vs_prev   = 1'b1;
            checking  = 1'b0;
            frame_ack = 1'b0;
            err_count = 0;
        end else begin
            h_fall = hs_prev && !vga_hsync;
            v_fall = vs_prev && !vga_vsync;
            if (h_fall) begin
                ox       = H_SYNC_START;
                h_locked = 1'b1;
            end else if (ox == H_TOTAL - 1) begin
                ox = 0;
                oy = (oy == V_TOTAL - 1) ? 0 : oy + 1;
            end else begin
                ox = ox + 1;
            end
            if (v_fall) begin
                oy       = V_SYNC_START;
                v_locked = 1'b1;
            end

            if (!frame_req)
                frame_ack = 1'b0;
            // A requested frame starts at the top left corner
            if (!checking && frame_req && !frame_ack && h_locked && v_locked
                    && ox == 0 && oy == 0) begin
                checking   = 1'b1;
                hs_falls   = 0;
                vs_falls   = 0;
                hs_low     = 0;
                vs_low     = 0;
                line_px    = 0;
                lit_lines  = 0;
                lit_pixels = 0;
            end

            if (checking) begin
                got = {vga_r, vga_g, vga_b};
                exp = ovl_tb.expected_pixel(ox, oy);
                if (got !== exp) begin
                    err_count++;
                    $display("Fail at %0t: pixel (%0d,%0d) is %h, expected %h",
                             $time, ox, oy, got, exp);
                end
                if (got != 0)
                    line_px++;
                if (h_fall)
                    hs_falls++;
                if (v_fall)
                    vs_falls++;
                // Sync widths, counted in pixels
                if (!vga_hsync)
                    hs_low++;
                if (!vga_vsync)
                    vs_low++;
                if (ox == H_TOTAL - 1) begin
                    if (line_px > 0)
                        lit_lines++;
                    lit_pixels += line_px;
                    line_px = 0;
                    if (oy == V_TOTAL - 1) begin
                        checking  = 1'b0;
                        frame_ack = 1'b1;
                        if (hs_falls != V_TOTAL || vs_falls != 1) begin
                            err_count++;
                            $display("Fail at %0t: %0d hsync and %0d vsync pulses in a frame",
                                     $time, hs_falls, vs_falls);
                        end
                        if (hs_low != V_TOTAL * H_SYNC_LEN
                                || vs_low != V_SYNC_LEN * H_TOTAL) begin
                            err_count++;
                            $display("Fail at %0t: hsync/vsync low for %0d/%0d pixels",
                                     $time, hs_low, vs_low);
                        end
                    end
                end
            end
            hs_prev = vga_hsync;
            vs_prev = vga_vsync;
        end
    end

endmodule

//--- tb/ovl_sva.sv
module ovl_sva (
    input logic clk,
    input logic reset,
    input logic wr_pulse,
    input logic msg_end,
    input logic in_idle,
    input logic de,
    input logic hsync
);

    int fail_count = 0;

    // Write strobe is a single cycle
    wr_single: assert property (@(posedge clk) disable iff (reset) wr_pulse |=> !wr_pulse)
        else begin
            fail_count++;
            $error("write strobe high for two cycles in a row");
        end

    msg_end_idle: assert property (@(posedge clk) disable iff (reset) msg_end |=> in_idle)
        else begin
            fail_count++;
            $error("decoder not idle one cycle after message end");
        end

    // No active video inside the horizontal sync
    de_outside_sync: assert property (@(posedge clk) disable iff (reset) de |-> hsync)
        else begin
            fail_count++;
            $error("data enable high while hsync is low");
        end

endmodule

bind spi_msg_fsm ovl_sva sva_i (
    .clk(clk),
    .reset(reset),
    .wr_pulse(wr.wr),
    .msg_end(msg_end),
    .in_idle(state == ovl_pkg::IDLE),
    .de(1'b0),
    .hsync(1'b1)
);

bind scan_timer ovl_sva sva_i (
    .clk(clk),
    .reset(reset),
    .wr_pulse(1'b0),
    .msg_end(1'b0),
    .in_idle(1'b1),
    .de(de),
    .hsync(hsync)
);

//--- tb/ovl_tb.sv
module ovl_tb;
    import ovl_pkg::*;

    localparam int H_ACTIVE      = 64;
    localparam int V_ACTIVE      = 32;
    localparam int H_TOTAL       = 72;
    localparam int V_TOTAL       = 36;
    localparam int H_SYNC_START  = 66;
    localparam int H_SYNC_LEN    = 3;
    localparam int V_SYNC_START  = 33;
    localparam int V_SYNC_LEN    = 1;
    localparam int NUM_CELLS     = (H_ACTIVE / 8) * (V_ACTIVE / 8);
    localparam int SCLK_PHASE    = 5;
    localparam int FRAME_TIMEOUT = 4 * H_TOTAL * V_TOTAL;

    logic       clk;
    logic       reset;
    logic       esp_ssel_n;
    logic       esp_sclk;
    logic       esp_mosi;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;
    logic       vga_hsync;
    logic       vga_vsync;
    logic       frame_req;
    logic       frame_ack;
    int         chk_errors;
    int         lit_lines;
    int         lit_pixels;

    // Shadow of what the decoder should have written
    pal_idx_t    shadow_cells [1024];
    rgb_t        shadow_pal [16];
    spi_byte_t   msg_data [$];
    logic [31:0] rng;
    int          tb_errors;
    int          tests_run;
    int          tests_failed;
    int          errors_before;

    tb_clk clk_i (
        .clk(clk),
        .reset(reset)
    );

    ovl_top #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE),
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL),
        .H_SYNC_START(H_SYNC_START),
        .H_SYNC_LEN(H_SYNC_LEN),
        .V_SYNC_START(V_SYNC_START),
        .V_SYNC_LEN(V_SYNC_LEN)
    ) dut_i (
        .clk(clk),
        .reset(reset),
        .esp_ssel_n(esp_ssel_n),
        .esp_sclk(esp_sclk),
        .esp_mosi(esp_mosi),
        .vga_r(vga_r),
        .vga_g(vga_g),
        .vga_b(vga_b),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync)
    );

    ovl_checker #(
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL),
        .H_SYNC_START(H_SYNC_START),
        .H_SYNC_LEN(H_SYNC_LEN),
        .V_SYNC_START(V_SYNC_START),
        .V_SYNC_LEN(V_SYNC_LEN)
    ) chk_i (
        .clk(clk),
        .reset(reset),
        .vga_r(vga_r),
        .vga_g(vga_g),
        .vga_b(vga_b),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .frame_req(frame_req),
        .frame_ack(frame_ack),
        .err_count(chk_errors),
        .lit_lines(lit_lines),
        .lit_pixels(lit_pixels)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Colour at a raster position, black outside the active area
    function automatic rgb_t expected_pixel(input int px, input int py);
        if (px >= H_ACTIVE || py >= V_ACTIVE)
            return '0;
        return shadow_pal[shadow_cells[(py / 8) * (H_ACTIVE / 8) + px / 8]];
    endfunction

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_timeout(input string why);
        tb_errors++;
        $display("Error at %0t: %s", $time, why);
    endtask

    //////////////////////////////////////////////////////////////////////
    // SPI mode 0 driver, MSB first
    //////////////////////////////////////////////////////////////////////
    task automatic spi_byte(input spi_byte_t b);
        for (int i = 7; i >= 0; i--) begin
            esp_mosi = b[i];
            step(SCLK_PHASE);
            esp_sclk = 1'b1;
            step(SCLK_PHASE);
            esp_sclk = 1'b0;
        end
    endtask

    task automatic send_msg(input spi_byte_t cmd, input int addr);
        int a;
        esp_ssel_n = 1'b0;
        step(SCLK_PHASE);
        spi_byte(cmd);
        spi_byte(addr[7:0]);
        spi_byte(addr[15:8]);
        foreach (msg_data[i])
            spi_byte(msg_data[i]);
        step(SCLK_PHASE);
        esp_ssel_n = 1'b1;
        step(12);
        // Cells take every byte, the palette complete byte pairs
        a = addr;
        if (cmd == CMD_CELL_WR) begin
            foreach (msg_data[i]) begin
                shadow_cells[a % 1024] = msg_data[i][3:0];
                a++;
            end
        end else if (cmd == CMD_PAL_WR) begin
            for (int i = 0; i + 1 < msg_data.size(); i += 2) begin
                shadow_pal[a % 16] = {msg_data[i + 1][3:0], msg_data[i]};
                a++;
            end
        end
    endtask

    task automatic load_cells();
        msg_data.delete();
        for (int i = 0; i < NUM_CELLS; i++) begin
            rng = xorshift(rng);
            msg_data.push_back(rng[7:0]);
        end
        send_msg(CMD_CELL_WR, 0);
    endtask

    // Nonzero colours, so every active pixel lights up
    task automatic load_palette(input int first, input int count);
        msg_data.delete();
        for (int i = 0; i < count; i++) begin
            rng = xorshift(rng);
            msg_data.push_back(rng[7:0] | 8'h01);
            msg_data.push_back(rng[15:8]);
        end
        send_msg(CMD_PAL_WR, first);
    endtask

    task automatic send_random_msg();
        int len;
        int addr;
        spi_byte_t cmd;
        rng = xorshift(rng);
        cmd  = rng[0] ? CMD_PAL_WR : CMD_CELL_WR;
        len  = 1 + int'(rng[8:4]) % 12;
        addr = rng[0] ? int'(rng[19:16]) : int'(rng[29:20]) % (NUM_CELLS + 8);
        msg_data.delete();
        for (int i = 0; i < len; i++) begin
            rng = xorshift(rng);
            msg_data.push_back(rng[7:0]);
        end
        send_msg(cmd, addr);
    endtask

    task automatic check_frame();
        int waited;
        frame_req = 1'b1;
        waited = 0;
        while (!frame_ack && waited < FRAME_TIMEOUT) begin
            step(1);
            waited++;
        end
        if (!frame_ack)
            report_timeout("no frame was compared within the time limit");
        frame_req = 1'b0;
        waited = 0;
        while (frame_ack && waited < 10) begin
            step(1);
            waited++;
        end
        if (frame_ack)
            report_timeout("checker kept its frame acknowledge high");
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = tb_errors + chk_errors - errors_before;
        tests_run++;
        if (errs == 0) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errs);
        end
        errors_before = tb_errors + chk_errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int waited;
        int total;
        esp_ssel_n    = 1'b1;
        esp_sclk      = 1'b0;
        esp_mosi      = 1'b0;
        frame_req     = 1'b0;
        rng           = 32'd47001;
        tb_errors     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        errors_before = 0;
        foreach (shadow_pal[i])
            shadow_pal[i] = '0;

        step(2);
        if (vga_hsync !== 1'b1 || vga_vsync !== 1'b1 || {vga_r, vga_g, vga_b} !== 12'h000) begin
            tb_errors++;
            $display("Fail at %0t: in reset hsync %b vsync %b colour %h",
                     $time, vga_hsync, vga_vsync, {vga_r, vga_g, vga_b});
        end
        waited = 0;
        while (reset && waited < 20) begin
            step(1);
            waited++;
        end
        if (reset)
            report_timeout("reset was never released");
        load_cells();
        load_palette(0, 16);
        check_frame();
        if (lit_lines != V_ACTIVE || lit_pixels != V_ACTIVE * H_ACTIVE) begin
            tb_errors++;
            $display("Fail at %0t: %0d active lines and %0d active pixels",
                     $time, lit_lines, lit_pixels);
        end
        finish_test("reset and raster");

        load_cells();
        load_palette(0, 8);
        load_palette(8, 8);
        check_frame();
        finish_test("all cells and palette");

        // Entries 12 to 15, then 0 to 3
        load_palette(12, 8);
        check_frame();
        finish_test("palette wrap");

        msg_data.delete();
        for (int i = 0; i < 6; i++) begin
            rng = xorshift(rng);
            msg_data.push_back(rng[7:0]);
        end
        send_msg(8'h33, 0);
        check_frame();
        msg_data.delete();
        for (int i = 0; i < 5; i++) begin
            rng = xorshift(rng);
            msg_data.push_back(rng[7:0]);
        end
        send_msg(CMD_PAL_WR, 5);
        check_frame();
        finish_test("unknown command and short palette");

        for (int n = 0; n < 20; n++) begin
            send_random_msg();
            check_frame();
            finish_test($sformatf("random message %0d", n + 1));
        end

        total = tb_errors + chk_errors + dut_i.msg_fsm_i.sva_i.fail_count
              + dut_i.scan_i.sva_i.fail_count;
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, total);
        if (total == 0 && tests_failed == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- flist.f
logic/ovl_pkg.sv
logic/ovl_wr_if.sv
logic/spi_byte_rx.sv
logic/spi_msg_fsm.sv
logic/scan_timer.sv
logic/overlay_mem.sv
logic/ovl_top.sv
tb/tb_clk.sv
tb/ovl_checker.sv
tb/ovl_sva.sv
tb/ovl_tb.sv
